// ==== source/prbs_pkg.sv ====
package prbs_pkg;

	localparam int BYTE_W = 8; // One lane byte.
	localparam int LANES = 8; // Byte lanes per block.
	localparam int BLOCK_W = BYTE_W * LANES;

	// PRBS11 register, polynomial x^11 + x^9 + 1.
	localparam int PRBS_W = 11;

	// Lane 0 drives the most significant byte of the block.
	localparam logic [PRBS_W-1:0] LANE_SEEDS [LANES] = '{
		11'h5A3,
		11'h7BE,
		11'h2AA,
		11'h4ED,
		11'h3BA,
		11'h7AE,
		11'h5CA,
		11'h2DC
	};

	localparam int CNT_W = 16; // Burst length and error counters.

	typedef enum logic [1:0] {
		IDLE	= 2'd0,
		RUN	= 2'd1,
		DRAIN	= 2'd2
	} seq_state_t;

endpackage

// ==== source/prbs11_lane.sv ====
`timescale 1ns/1ps

module prbs11_lane
	#(
	parameter logic [prbs_pkg::PRBS_W-1:0]	SEED	= 1,
	parameter int							BYTE_W	= prbs_pkg::BYTE_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_enable,
	input	logic							i_restart,
	output	logic	[BYTE_W-1:0]			o_sequence
	);

logic	[prbs_pkg::PRBS_W-1:0]	prbs_reg;
logic							feedback;

// Taps at bits 11 and 9 of the polynomial.
assign feedback = prbs_reg[10] ^ prbs_reg[8];

always_ff @(posedge i_clock) begin
	if (!i_rst_n) begin
		prbs_reg <= SEED;
	end else if (i_restart) begin
		prbs_reg <= SEED; // A restart wins over a step in the same cycle.
	end else if (i_enable) begin
		prbs_reg <= {prbs_reg[prbs_pkg::PRBS_W-2:0], feedback};
	end
end

assign o_sequence = prbs_reg[BYTE_W-1:0];

endmodule

// ==== source/data_generator.sv ====
`timescale 1ns/1ps

module data_generator
	#(
	parameter int							BYTE_W	= prbs_pkg::BYTE_W,
	parameter int							LANES	= prbs_pkg::LANES
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_enable,
	input	logic							i_restart,
	output	logic	[BYTE_W*LANES-1:0]		o_data_block
	);

genvar	lane;

generate
	for (lane = 0; lane < LANES; lane++) begin : g_lane
		logic	[BYTE_W-1:0]	lane_byte;

		prbs11_lane#(
			.SEED(prbs_pkg::LANE_SEEDS[lane]),
			.BYTE_W(BYTE_W)
			)
		u_prbs11
			(
			.i_clock(i_clock),
			.i_rst_n(i_rst_n),
			.i_enable(i_enable),
			.i_restart(i_restart),
			.o_sequence(lane_byte)
			);

		// Lane 0 lands in the top byte.
		assign o_data_block[(LANES-1-lane)*BYTE_W +: BYTE_W] = lane_byte;
	end
endgenerate

endmodule

// ==== source/block_counter.sv ====
`timescale 1ns/1ps

module block_counter
	#(
	parameter int							CNT_W	= prbs_pkg::CNT_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_clear,
	input	logic							i_count,
	input	logic	[CNT_W-1:0]				i_burst_len,
	output	logic							o_last
	);

logic	[CNT_W-1:0]	block_cnt;

always_ff @(posedge i_clock) begin
	if (!i_rst_n) begin
		block_cnt <= '0;
	end else if (i_clear) begin
		block_cnt <= '0;
	end else if (i_count) begin
		block_cnt <= block_cnt + CNT_W'(1);
	end
end

// The count equals the number of blocks already sent in this burst.
assign o_last = (block_cnt == i_burst_len - CNT_W'(1));

endmodule

// ==== source/test_sequencer.sv ====
`timescale 1ns/1ps

module test_sequencer
	#(
	parameter int							CNT_W	= prbs_pkg::CNT_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_start,
	input	logic							i_last,
	input	logic	[CNT_W-1:0]				i_burst_len,
	output	logic							o_restart,
	output	logic							o_tx_valid,
	output	logic							o_busy,
	output	logic							o_done
	);

prbs_pkg::seq_state_t	state;
logic					drain_cnt;
logic					accept;

// Starts are only taken when idle and with a real length.
assign accept		= (state == prbs_pkg::IDLE) && i_start && (i_burst_len != '0);
assign o_restart	= accept;
assign o_tx_valid	= (state == prbs_pkg::RUN);
assign o_busy		= (state != prbs_pkg::IDLE);

always_ff @(posedge i_clock) begin
	if (!i_rst_n) begin
		state		<= prbs_pkg::IDLE;
		drain_cnt	<= 1'b0;
		o_done		<= 1'b0;
	end else begin
		o_done <= 1'b0;
		case (state)
			prbs_pkg::IDLE: begin
				if (accept) begin
					state <= prbs_pkg::RUN;
				end
			end
			prbs_pkg::RUN: begin
				if (i_last) begin
					state		<= prbs_pkg::DRAIN;
					drain_cnt	<= 1'b0;
				end
			end
			prbs_pkg::DRAIN: begin
				// Two cycles cover the channel stage and the checker counters.
				if (drain_cnt) begin
					state	<= prbs_pkg::IDLE;
					o_done	<= 1'b1;
				end else begin
					drain_cnt <= 1'b1;
				end
			end
			default: begin
				state <= prbs_pkg::IDLE;
			end
		endcase
	end
end

endmodule

// ==== source/error_channel.sv ====
`timescale 1ns/1ps

module error_channel
	#(
	parameter int							BLOCK_W	= prbs_pkg::BLOCK_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_valid,
	input	logic	[BLOCK_W-1:0]			i_block,
	input	logic	[BLOCK_W-1:0]			i_inject_mask,
	output	logic							o_valid,
	output	logic	[BLOCK_W-1:0]			o_block
	);

always_ff @(posedge i_clock) begin
	if (!i_rst_n) begin
		o_valid <= 1'b0;
	end else begin
		o_valid <= i_valid;
	end
end

// Only blocks that carry data are corrupted.
always_ff @(posedge i_clock) begin
	if (i_valid) begin
		o_block <= i_block ^ i_inject_mask;
	end else begin
		o_block <= i_block;
	end
end

endmodule

// ==== source/data_checker.sv ====
`timescale 1ns/1ps

module data_checker
	#(
	parameter int							BYTE_W	= prbs_pkg::BYTE_W,
	parameter int							LANES	= prbs_pkg::LANES,
	parameter int							CNT_W	= prbs_pkg::CNT_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_clear,
	input	logic							i_valid,
	input	logic	[BYTE_W*LANES-1:0]		i_block,
	output	logic	[CNT_W-1:0]				o_block_errors,
	output	logic	[CNT_W-1:0]				o_bit_errors
	);

localparam int	BLOCK_W	= BYTE_W * LANES;
localparam int	POP_W	= $clog2(BLOCK_W + 1);
localparam int	SUM_W	= CNT_W + 1;

logic	[BLOCK_W-1:0]	ref_block;
logic	[BLOCK_W-1:0]	diff;
logic	[POP_W-1:0]		diff_ones;
logic	[SUM_W-1:0]		bit_sum;

data_generator#(
	.BYTE_W(BYTE_W),
	.LANES(LANES)
	)
u_ref_generator
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_enable(i_valid), // The reference advances once per received block.
	.i_restart(i_clear),
	.o_data_block(ref_block)
	);

assign diff = i_block ^ ref_block;

always_comb begin
	diff_ones = '0;
	for (int b = 0; b < BLOCK_W; b++) begin
		diff_ones = diff_ones + POP_W'(diff[b]);
	end
end

assign bit_sum = {1'b0, o_bit_errors} + SUM_W'(diff_ones);

always_ff @(posedge i_clock) begin
	if (!i_rst_n || i_clear) begin
		o_block_errors	<= '0;
		o_bit_errors	<= '0;
	end else if (i_valid) begin
		if ((diff != '0) && (o_block_errors != '1)) begin
			o_block_errors <= o_block_errors + CNT_W'(1);
		end
		// Saturate when the carry bit is set.
		o_bit_errors <= bit_sum[CNT_W] ? '1 : bit_sum[CNT_W-1:0];
	end
end

endmodule

// ==== source/prbs_tester_top.sv ====
`timescale 1ns/1ps

module prbs_tester_top
	#(
	parameter int							BYTE_W	= prbs_pkg::BYTE_W,
	parameter int							LANES	= prbs_pkg::LANES,
	parameter int							CNT_W	= prbs_pkg::CNT_W
	)
	(
	input	logic							i_clock,
	input	logic							i_rst_n,
	input	logic							i_start,
	input	logic	[CNT_W-1:0]				i_burst_len,
	input	logic	[BYTE_W*LANES-1:0]		i_inject_mask,
	output	logic	[BYTE_W*LANES-1:0]		o_tx_block,
	output	logic							o_tx_valid,
	output	logic							o_busy,
	output	logic							o_done,
	output	logic	[CNT_W-1:0]				o_block_errors,
	output	logic	[CNT_W-1:0]				o_bit_errors
	);

localparam int	BLOCK_W	= BYTE_W * LANES;

logic					restart;
logic					last;
logic					rx_valid;
logic	[BLOCK_W-1:0]	rx_block;

test_sequencer#(
	.CNT_W(CNT_W)
	)
u_sequencer
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_start(i_start),
	.i_last(last),
	.i_burst_len(i_burst_len),
	.o_restart(restart),
	.o_tx_valid(o_tx_valid),
	.o_busy(o_busy),
	.o_done(o_done)
	);

block_counter#(
	.CNT_W(CNT_W)
	)
u_block_counter
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_clear(restart),
	.i_count(o_tx_valid),
	.i_burst_len(i_burst_len),
	.o_last(last)
	);

data_generator#(
	.BYTE_W(BYTE_W),
	.LANES(LANES)
	)
u_tx_generator
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_enable(o_tx_valid),
	.i_restart(restart),
	.o_data_block(o_tx_block)
	);

error_channel#(
	.BLOCK_W(BLOCK_W)
	)
u_error_channel
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_valid(o_tx_valid),
	.i_block(o_tx_block),
	.i_inject_mask(i_inject_mask),
	.o_valid(rx_valid),
	.o_block(rx_block)
	);

data_checker#(
	.BYTE_W(BYTE_W),
	.LANES(LANES),
	.CNT_W(CNT_W)
	)
u_data_checker
	(
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_clear(restart),
	.i_valid(rx_valid),
	.i_block(rx_block),
	.o_block_errors(o_block_errors),
	.o_bit_errors(o_bit_errors)
	);

endmodule

// ==== verif/prbs_tester_asserts.sv ====
`timescale 1ns/1ps

module prbs_tester_asserts (
	input	logic					i_clock,
	input	logic					i_rst_n,
	input	logic					i_tx_valid,
	input	logic					i_busy,
	input	logic					i_done,
	input	prbs_pkg::seq_state_t	i_state
);

// Done only comes after the drain, never during transmit.
no_done_with_valid: assert property (@(posedge i_clock) disable iff (!i_rst_n)
	!(i_done && i_tx_valid)) else $error("o_done high together with o_tx_valid");

done_one_cycle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
	i_done |=> !i_done) else $error("o_done lasted more than one cycle");

valid_implies_busy: assert property (@(posedge i_clock) disable iff (!i_rst_n)
	i_tx_valid |-> i_busy) else $error("o_tx_valid high while o_busy is low");

legal_state: assert property (@(posedge i_clock) disable iff (!i_rst_n)
	(i_state == prbs_pkg::IDLE) || (i_state == prbs_pkg::RUN) ||
	(i_state == prbs_pkg::DRAIN)) else $error("sequencer state is not legal");

endmodule

bind prbs_tester_top prbs_tester_asserts u_asserts (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_tx_valid(o_tx_valid),
	.i_busy(o_busy),
	.i_done(o_done),
	.i_state(u_sequencer.state)
);

// ==== verif/prbs_tester_tb.sv ====
`timescale 1ns/1ps

module prbs_tester_tb;

localparam int	BLOCK_W			= prbs_pkg::BLOCK_W;
localparam int	CNT_W			= prbs_pkg::CNT_W;
localparam int	LANES			= prbs_pkg::LANES;
localparam int	NUM_ROWS		= 8;
localparam int	TIMEOUT_CYCLES	= 200;
localparam int	ZERO_WATCH		= 6;

logic					i_clock;
logic					i_rst_n;
logic					i_start;
logic	[CNT_W-1:0]		i_burst_len;
logic	[BLOCK_W-1:0]	i_inject_mask;
logic	[BLOCK_W-1:0]	o_tx_block;
logic					o_tx_valid;
logic					o_busy;
logic					o_done;
logic	[CNT_W-1:0]		o_block_errors;
logic	[CNT_W-1:0]		o_bit_errors;

// A zero length row checks that the start is ignored.
logic	[CNT_W-1:0]		row_len		[NUM_ROWS] = '{16'd5, 16'd1, 16'd8, 16'd12,
													16'd0, 16'd20, 16'd33, 16'd3};
logic	[BLOCK_W-1:0]	row_mask	[NUM_ROWS] = '{64'h0, 64'h0, 64'h1,
													64'hFF00_0000_0000_0081,
													64'h0000_0001_0000_0000, 64'h0, 64'h0,
													64'hFFFF_FFFF_FFFF_FFFF};
logic					row_random	[NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0,
													1'b0, 1'b1, 1'b1, 1'b0};
logic					row_poke	[NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1,
													1'b1, 1'b0, 1'b1, 1'b0};

logic	[prbs_pkg::PRBS_W-1:0]	model_lane	[LANES];
logic	[31:0]					lfsr_state;
int								value_errors;
int								other_errors;
int								last_blocks;
int								last_bits;
logic							timed_out;

prbs_tester_top prbs_tester_top_i (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_start(i_start),
	.i_burst_len(i_burst_len),
	.i_inject_mask(i_inject_mask),
	.o_tx_block(o_tx_block),
	.o_tx_valid(o_tx_valid),
	.o_busy(o_busy),
	.o_done(o_done),
	.o_block_errors(o_block_errors),
	.o_bit_errors(o_bit_errors)
);

initial i_clock = 1'b0;
always #5 i_clock = ~i_clock;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003; // Taps 32, 22, 2, 1.
	end
	return s >> 1;
endfunction

task automatic draw_mask(output logic [BLOCK_W-1:0] mask);
	for (int b = 0; b < BLOCK_W; b++) begin
		mask[b] = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

function automatic int count_ones(input logic [BLOCK_W-1:0] v);
	int n;
	n = 0;
	for (int b = 0; b < BLOCK_W; b++) begin
		if (v[b]) begin
			n++;
		end
	end
	return n;
endfunction

task automatic model_restart();
	for (int l = 0; l < LANES; l++) begin
		model_lane[l] = prbs_pkg::LANE_SEEDS[l];
	end
endtask

task automatic model_step();
	for (int l = 0; l < LANES; l++) begin
		model_lane[l] = {model_lane[l][9:0], model_lane[l][10] ^ model_lane[l][8]};
	end
endtask

function automatic logic [BLOCK_W-1:0] model_block();
	logic [BLOCK_W-1:0] blk;
	for (int l = 0; l < LANES; l++) begin
		blk[(LANES-1-l)*8 +: 8] = model_lane[l][7:0]; // Lane 0 is the top byte.
	end
	return blk;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		value_errors++;
		$display("ERROR: time %0t, %s = %0h, expected %0h", $time, name, got, exp);
	end
endtask

task automatic report_failure(input string what);
	other_errors++;
	$display("Failure at time %0t: %s", $time, what);
endtask

task automatic run_burst(input logic [CNT_W-1:0] len, input logic [BLOCK_W-1:0] mask,
		input logic poke);
	int cycles;
	int first_valid;
	int last_valid;
	int valid_count;
	int done_cycle;
	int pop;
	model_restart();
	pop = count_ones(mask);
	last_blocks = (pop == 0) ? 0 : int'(len);
	last_bits = (pop == 0) ? 0 : int'(len) * pop;
	if (last_bits > 65535) begin
		last_bits = 65535;
	end
	@(posedge i_clock);
	i_start			<= 1'b1;
	i_burst_len		<= len;
	i_inject_mask	<= mask;
	@(posedge i_clock);
	i_start <= 1'b0;
	cycles = 0;
	first_valid = -1;
	last_valid = -1;
	valid_count = 0;
	done_cycle = -1;
	while (done_cycle < 0 && cycles < TIMEOUT_CYCLES) begin
		@(negedge i_clock);
		cycles++;
		// Busy covers the burst and the two drain cycles.
		check_value("o_busy", 64'(o_busy), (cycles <= int'(len) + 2) ? 64'd1 : 64'd0);
		if (o_tx_valid) begin
			if (first_valid < 0) begin
				first_valid = cycles;
			end
			if (last_valid >= 0 && last_valid != cycles - 1) begin
				report_failure("o_tx_valid fell and rose again inside one burst");
			end
			check_value("o_tx_block", o_tx_block, model_block());
			model_step();
			last_valid = cycles;
			valid_count++;
		end
		if (o_done) begin
			done_cycle = cycles;
			check_value("o_block_errors", 64'(o_block_errors), 64'(last_blocks));
			check_value("o_bit_errors", 64'(o_bit_errors), 64'(last_bits));
		end else begin
			@(posedge i_clock);
			i_start <= poke && (cycles == 2); // A second start while the burst runs.
		end
	end
	if (done_cycle < 0) begin
		report_failure("o_done did not arrive within the timeout");
		timed_out = 1'b1;
	end else begin
		check_value("o_tx_valid length", 64'(valid_count), 64'(len));
		check_value("o_tx_valid first cycle", 64'(first_valid), 64'd1);
		check_value("o_done delay", 64'(done_cycle - last_valid), 64'd3);
	end
endtask

task automatic zero_len_start(input logic [BLOCK_W-1:0] mask);
	@(posedge i_clock);
	i_start			<= 1'b1;
	i_burst_len		<= '0;
	i_inject_mask	<= mask;
	@(posedge i_clock);
	i_start <= 1'b0;
	for (int c = 0; c < ZERO_WATCH; c++) begin
		@(negedge i_clock);
		if (o_busy || o_tx_valid || o_done) begin
			report_failure("a start with zero length began a burst");
		end
	end
	check_value("o_block_errors", 64'(o_block_errors), 64'(last_blocks));
	check_value("o_bit_errors", 64'(o_bit_errors), 64'(last_bits));
endtask

initial begin
	logic [BLOCK_W-1:0] mask;
	i_rst_n = 1'b0;
	i_start = 1'b0;
	i_burst_len = '0;
	i_inject_mask = '0;
	value_errors = 0;
	other_errors = 0;
	last_blocks = 0;
	last_bits = 0;
	timed_out = 1'b0;
	lfsr_state = 32'h4f896428;
	repeat (16) @(posedge i_clock);
	i_rst_n <= 1'b1;
	@(negedge i_clock);
	check_value("o_tx_valid", 64'(o_tx_valid), 64'd0);
	check_value("o_busy", 64'(o_busy), 64'd0);
	check_value("o_done", 64'(o_done), 64'd0);
	check_value("o_block_errors", 64'(o_block_errors), 64'd0);
	check_value("o_bit_errors", 64'(o_bit_errors), 64'd0);
	for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
		if (row_random[r]) begin
			draw_mask(mask);
		end else begin
			mask = row_mask[r];
		end
		if (row_len[r] == '0) begin
			zero_len_start(mask);
		end else begin
			run_burst(row_len[r], mask, row_poke[r]);
		end
	end
	$display("Value errors: %0d, other failures: %0d", value_errors, other_errors);
	if (value_errors == 0 && other_errors == 0) begin
		$display("Result: PASSED");
	end else begin
		$display("Result: FAILED");
	end
	$finish;
end

endmodule

// ==== prbs_tester.f ====
source/prbs_pkg.sv
source/prbs11_lane.sv
source/data_generator.sv
source/block_counter.sv
source/test_sequencer.sv
source/error_channel.sv
source/data_checker.sv
source/prbs_tester_top.sv
verif/prbs_tester_asserts.sv
verif/prbs_tester_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the PRBS tester simulation with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
	--top-module prbs_tester_tb \
	-f prbs_tester.f \
	--Mdir obj_dir \
	-o prbs_tester_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/prbs_tester_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
